//--- pwmCtrl.f
src/pwmPkg.sv
src/ckeGenerator.sv
src/dutyGenerator.sv
src/pwmRegs.sv
src/pwmCtrlTop.sv
verif/tbClock.sv
verif/pwmCtrlTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the PWM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f pwmCtrl.f --top-module pwmCtrlTb \
	--Mdir obj_dir -o pwmCtrlSim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/pwmCtrlSim > sim.log 2>&1 || true

grep -q "Simulation passed" sim.log && echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

//--- src/ckeGenerator.sv
`default_nettype none

// Interval timer with a period of div + 1 clocks
module ckeGenerator
	import pwmPkg::*;
(
	input  wire logic                  iCLK,
	input  wire logic                  iRST,
	input  wire logic                  en,    // Run enable
	input  wire logic [lpDivWidth-1:0] div,   // Divide value
	output logic                       cke    // One clock per period
);

	logic [lpDivWidth-1:0] cnt;      // Position inside the period
	logic [lpDivWidth-1:0] divReg;   // Divide value of the running period
	logic [lpDivWidth-1:0] divEff;   // Terminal count in use
	logic                  atEnd;

	// At count zero the live value applies, later the held copy
	assign divEff = (cnt == '0) ? div : divReg;
	assign atEnd  = (cnt == divEff);
	assign cke    = en & atEnd;      // Stops at once when disabled

	always_ff @(posedge iCLK)
	begin
		if (iRST || !en)
			cnt <= '0;                // Idle at zero
		else if (atEnd)
			cnt <= '0;                // Period boundary
		else
			cnt <= cnt + lpDivWidth'(1);
	end

	// Reload only at a period start
	always_ff @(posedge iCLK)
	begin
		if (cnt == '0)
			divReg <= div;
	end

endmodule

`default_nettype wire

//--- src/dutyGenerator.sv
`default_nettype none

// One PWM channel
module dutyGenerator
	import pwmPkg::*;
(
	input  wire logic                   iCLK,
	input  wire logic                   iRST,
	input  wire logic                   en,            // Channel enable
	input  wire logic [lpDutyWidth-1:0] dutyRatio,     // Larger gives shorter high time
	input  wire logic [lpDivWidth-1:0]  divValue,      // Interval timer divide
	output logic                        pwm,
	output logic                        dutyCycleCke   // Pulse per full duty cycle
);

	logic                   stepCke;   // Duty counter step
	logic [lpDutyWidth-1:0] dutyCnt;

	// ----------------------------------------
	// Interval timer
	// ----------------------------------------
	ckeGenerator ckeGen (
		.iCLK (iCLK),
		.iRST (iRST),
		.en   (en),
		.div  (divValue),
		.cke  (stepCke)
	);

	// ----------------------------------------
	// Duty counter and compare
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST || !en)
			dutyCnt <= '0;
		else if (stepCke)
			dutyCnt <= dutyCnt + lpDutyWidth'(1);   // Wraps after lpDutyMax
	end

	// High while the count is above the ratio
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			pwm <= 1'b0;
		else
			pwm <= en & (dutyCnt > dutyRatio);
	end

	// Last step of the cycle
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			dutyCycleCke <= 1'b0;
		else
			dutyCycleCke <= stepCke & (dutyCnt == lpDutyMax);
	end

endmodule

`default_nettype wire

//--- src/pwmCtrlTop.sv
`default_nettype none

// Four channel PWM controller
module pwmCtrlTop
	import pwmPkg::*;
(
	input  wire logic                     iCLK,
	input  wire logic                     iRST,
	// Wishbone classic slave
	input  wire logic                     iWbCyc,
	input  wire logic                     iWbStb,
	input  wire logic                     iWbWe,
	input  wire logic [lpWbAdrWidth-1:0]  iWbAdr,
	input  wire logic [lpWbDataWidth-1:0] iWbDat,
	input  wire logic [lpWbSelWidth-1:0]  iWbSel,
	output logic      [lpWbDataWidth-1:0] oWbDat,
	output logic                          oWbAck,
	// Outputs
	output logic      [lpChannels-1:0]    oPwm,
	output logic                          oIrq     // Cycle completion interrupt
);

	logic [lpChannels-1:0]                  chanEn;
	logic [lpChannels-1:0][lpDutyWidth-1:0] dutyRatio;
	logic [lpChannels-1:0][lpDivWidth-1:0]  divValue;
	logic [lpChannels-1:0]                  cycleCke;   // Back to status bits

	// ----------------------------------------
	// Registers
	// ----------------------------------------
	pwmRegs regs (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.iWbCyc       (iWbCyc),
		.iWbStb       (iWbStb),
		.iWbWe        (iWbWe),
		.iWbAdr       (iWbAdr),
		.iWbDat       (iWbDat),
		.iWbSel       (iWbSel),
		.oWbDat       (oWbDat),
		.oWbAck       (oWbAck),
		.dutyCycleCke (cycleCke),
		.chanEn       (chanEn),
		.dutyRatio    (dutyRatio),
		.divValue     (divValue),
		.oIrq         (oIrq)
	);

	// ----------------------------------------
	// Channels
	// ----------------------------------------
	generate
		for (genvar ch = 0; ch < lpChannels; ch++)
		begin : gChan
			dutyGenerator dutyGen (
				.iCLK         (iCLK),
				.iRST         (iRST),
				.en           (chanEn[ch]),
				.dutyRatio    (dutyRatio[ch]),
				.divValue     (divValue[ch]),
				.pwm          (oPwm[ch]),
				.dutyCycleCke (cycleCke[ch])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- src/pwmPkg.sv
`default_nettype none

package pwmPkg;

	// ----------------------------------------
	// Sizes
	// ----------------------------------------
	localparam int lpChannels    = 4;   // PWM channels
	localparam int lpDutyWidth   = 8;   // Duty counter and ratio
	localparam int lpDivWidth    = 32;  // Interval timer divide value
	localparam int lpWbDataWidth = 32;  // Bus data
	localparam int lpWbAdrWidth  = 5;   // Word address taken from bus bits 6..2
	localparam int lpWbSelWidth  = lpWbDataWidth / 8;

	// Last duty count before wrap
	localparam logic [lpDutyWidth-1:0] lpDutyMax = '1;

	// ----------------------------------------
	// Register map in words
	// ----------------------------------------
	localparam int lpChanStride = 4;    // Words per channel block
	localparam int lpOffsCtrl   = 0;    // Enable
	localparam int lpOffsDuty   = 1;    // Ratio in the low byte
	localparam int lpOffsDiv    = 2;    // Full 32 bit divide value

	localparam int lpCtrlEnBit  = 0;    // Channel enable in CTRL

	// Interrupt registers, bit n is channel n
	localparam int lpAdrIrqStat = 16;   // Status, write one to clear
	localparam int lpAdrIrqEn   = 17;   // Enable mask

endpackage

`default_nettype wire

//--- src/pwmRegs.sv
`default_nettype none

// Wishbone classic register block
module pwmRegs
	import pwmPkg::*;
(
	input  wire logic                     iCLK,
	input  wire logic                     iRST,
	// Wishbone slave
	input  wire logic                     iWbCyc,
	input  wire logic                     iWbStb,
	input  wire logic                     iWbWe,
	input  wire logic [lpWbAdrWidth-1:0]  iWbAdr,    // Word address
	input  wire logic [lpWbDataWidth-1:0] iWbDat,
	input  wire logic [lpWbSelWidth-1:0]  iWbSel,
	output logic      [lpWbDataWidth-1:0] oWbDat,
	output logic                          oWbAck,
	// Channels
	input  wire logic [lpChannels-1:0]    dutyCycleCke,
	output logic      [lpChannels-1:0]    chanEn,
	output logic [lpChannels-1:0][lpDutyWidth-1:0] dutyRatio,
	output logic [lpChannels-1:0][lpDivWidth-1:0]  divValue,
	output logic                          oIrq
);

	logic                     wbReq;     // Request not yet acked
	logic                     wbWr;      // Write at the ack edge
	logic                     statWr;
	logic                     irqEnWr;
	logic [lpChannels-1:0]    statClr;   // Bits written with one
	logic [lpChannels-1:0]    irqStat;
	logic [lpChannels-1:0]    irqEn;
	logic [lpWbDataWidth-1:0] rdMux;

	// Channel register address
	function automatic logic [lpWbAdrWidth-1:0] chanAdr(input int ch, input int offs);
		return lpWbAdrWidth'(ch * lpChanStride + offs);
	endfunction

	// Old word with the selected bytes replaced
	function automatic logic [lpWbDataWidth-1:0] byteMerge(
		input logic [lpWbDataWidth-1:0] oldWord,
		input logic [lpWbDataWidth-1:0] newWord,
		input logic [lpWbSelWidth-1:0]  sel
	);
		logic [lpWbDataWidth-1:0] merged;
		merged = oldWord;
		for (int b = 0; b < lpWbSelWidth; b++)
		begin
			if (sel[b])
				merged[8*b +: 8] = newWord[8*b +: 8];
		end
		return merged;
	endfunction

	// ----------------------------------------
	// Bus handshake
	// ----------------------------------------
	assign wbReq   = iWbCyc & iWbStb & ~oWbAck;   // No back to back ack
	assign wbWr    = wbReq & iWbWe;
	assign statWr  = wbWr & (iWbAdr == lpWbAdrWidth'(lpAdrIrqStat)) & iWbSel[0];
	assign irqEnWr = wbWr & (iWbAdr == lpWbAdrWidth'(lpAdrIrqEn)) & iWbSel[0];
	assign statClr = {lpChannels{statWr}} & iWbDat[lpChannels-1:0];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			oWbAck <= 1'b0;
		else
			oWbAck <= wbReq;           // Single cycle, one clock late
	end

	// ----------------------------------------
	// Channel registers
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			chanEn    <= '0;            // All channels off
			dutyRatio <= '0;
			divValue  <= '0;
		end
		else if (wbWr)
		begin
			for (int ch = 0; ch < lpChannels; ch++)
			begin
				if (iWbAdr == chanAdr(ch, lpOffsCtrl) && iWbSel[lpCtrlEnBit / 8])
					chanEn[ch] <= iWbDat[lpCtrlEnBit];
				if (iWbAdr == chanAdr(ch, lpOffsDuty) && iWbSel[0])
					dutyRatio[ch] <= iWbDat[lpDutyWidth-1:0];   // Low byte only
				if (iWbAdr == chanAdr(ch, lpOffsDiv))
					divValue[ch] <= byteMerge(divValue[ch], iWbDat, iWbSel);
			end
		end
	end

	// ----------------------------------------
	// Interrupts
	// ----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			irqEn <= '0;
		else if (irqEnWr)
			irqEn <= iWbDat[lpChannels-1:0];
	end

	// A finished cycle beats a clear in the same clock
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			irqStat <= '0;
		else
		begin
			for (int ch = 0; ch < lpChannels; ch++)
			begin
				if (dutyCycleCke[ch])
					irqStat[ch] <= 1'b1;
				else if (statClr[ch])
					irqStat[ch] <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			oIrq <= 1'b0;
		else
			oIrq <= |(irqStat & irqEn);   // One clock behind status
	end

	// ----------------------------------------
	// Read path
	// ----------------------------------------
	always_comb
	begin
		rdMux = '0;                   // Unmapped reads zero
		for (int ch = 0; ch < lpChannels; ch++)
		begin
			if (iWbAdr == chanAdr(ch, lpOffsCtrl))
				rdMux[lpCtrlEnBit] = chanEn[ch];
			if (iWbAdr == chanAdr(ch, lpOffsDuty))
				rdMux = lpWbDataWidth'(dutyRatio[ch]);
			if (iWbAdr == chanAdr(ch, lpOffsDiv))
				rdMux = lpWbDataWidth'(divValue[ch]);
		end
		if (iWbAdr == lpWbAdrWidth'(lpAdrIrqStat))
			rdMux = lpWbDataWidth'(irqStat);
		if (iWbAdr == lpWbAdrWidth'(lpAdrIrqEn))
			rdMux = lpWbDataWidth'(irqEn);
	end

	// Loaded with the request so data sits in the ack cycle
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			oWbDat <= '0;
		else if (wbReq)
			oWbDat <= rdMux;
	end

endmodule

`default_nettype wire

//--- verif/pwmCtrlTb.sv
`default_nettype none

module pwmCtrlTb
	import pwmPkg::*;
;

	// ----------------------------------------
	// Run limits
	// ----------------------------------------
	localparam int lpWindow     = 256 * 4;                  // Longest duty cycle in clocks
	localparam int lpTestLen    = 7 * 2 * lpWindow + 2000;  // Duty windows plus bus traffic
	localparam int lpCycleLimit = 2 * lpTestLen;
	localparam int lpAckWait    = 16;

	logic                     iCLK;
	logic                     iRST;
	logic                     iWbCyc;
	logic                     iWbStb;
	logic                     iWbWe;
	logic [lpWbAdrWidth-1:0]  iWbAdr;
	logic [lpWbDataWidth-1:0] iWbDat;
	logic [lpWbSelWidth-1:0]  iWbSel;
	logic [lpWbDataWidth-1:0] oWbDat;
	logic                     oWbAck;
	logic [lpChannels-1:0]    oPwm;
	logic                     oIrq;

	int    errCount   = 0;
	int    checkCount = 0;
	int    testCount  = 0;
	int    errAtStart = 0;
	int    cycleCount = 0;
	string curTest    = "none";

	tbClock clkGen (
		.clk (iCLK),
		.rst (iRST)
	);

	pwmCtrlTop DUT (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.iWbCyc (iWbCyc),
		.iWbStb (iWbStb),
		.iWbWe  (iWbWe),
		.iWbAdr (iWbAdr),
		.iWbDat (iWbDat),
		.iWbSel (iWbSel),
		.oWbDat (oWbDat),
		.oWbAck (oWbAck),
		.oPwm   (oPwm),
		.oIrq   (oIrq)
	);

	// ----------------------------------------
	// Protocol and output checks
	// ----------------------------------------
	aAckSingle: assert property (@(posedge iCLK) disable iff (iRST) oWbAck |=> !oWbAck)
	else
	begin
		errCount++;
		$display("Bus error in %s: ack high for two cycles in a row", curTest);
	end

	aAckAfterReq: assert property (@(posedge iCLK) disable iff (iRST)
		oWbAck |-> $past(iWbCyc && iWbStb))
	else
	begin
		errCount++;
		$display("Bus error in %s: ack without a request", curTest);
	end

	generate
		for (genvar g = 0; g < lpChannels; g++)
		begin : gPwmOff
			// Registered pwm lags the enable by one clock
			aPwmOff: assert property (@(posedge iCLK) disable iff (iRST)
				(!DUT.chanEn[g] && !$past(DUT.chanEn[g])) |-> !oPwm[g])
			else
			begin
				errCount++;
				$display("Output error in %s: pwm high on disabled channel %0d", curTest, g);
			end
		end
	endgenerate

	// Hard stop
	always @(posedge iCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= lpCycleLimit)
		begin
			$display("Run stopped: cycle limit of %0d reached in %s", lpCycleLimit, curTest);
			$display("Simulation failed");
			$finish;
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [lpWbAdrWidth-1:0] regAddr(input int ch, input int offs);
		return lpWbAdrWidth'(ch * lpChanStride + offs);
	endfunction

	task automatic checkEq(input string what, input logic [31:0] exp, input logic [31:0] act);
		checkCount++;
		assert (act === exp)
		else
		begin
			errCount++;
			$display("CHECK FAILED %s %s expected %h actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic startTest(input string name);
		curTest    = name;
		errAtStart = errCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("Test %s finished with %0d errors", curTest, errCount - errAtStart);
	endtask

	task automatic waitAck();
		int n;
		n = 0;
		@(negedge iCLK);
		while (!oWbAck && n < lpAckWait)
		begin
			@(negedge iCLK);
			n++;
		end
		if (!oWbAck)
		begin
			errCount++;
			$display("Bus error in %s: no ack after %0d cycles", curTest, lpAckWait);
		end
	endtask

	task automatic wbWrite(input logic [4:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		@(posedge iCLK);
		iWbCyc <= 1'b1;
		iWbStb <= 1'b1;
		iWbWe  <= 1'b1;
		iWbAdr <= adr;
		iWbDat <= dat;
		iWbSel <= sel;
		waitAck();
		@(posedge iCLK);
		iWbCyc <= 1'b0;                // Drop after the ack
		iWbStb <= 1'b0;
		iWbWe  <= 1'b0;
	endtask

	task automatic wbRead(input logic [4:0] adr, output logic [31:0] dat);
		@(posedge iCLK);
		iWbCyc <= 1'b1;
		iWbStb <= 1'b1;
		iWbWe  <= 1'b0;
		iWbAdr <= adr;
		iWbSel <= 4'hF;
		waitAck();
		dat = oWbDat;                  // Valid in the ack cycle
		@(posedge iCLK);
		iWbCyc <= 1'b0;
		iWbStb <= 1'b0;
	endtask

	task automatic readCheck(input string what, input logic [4:0] adr, input logic [31:0] exp);
		logic [31:0] got;
		wbRead(adr, got);
		checkEq(what, exp, got);
	endtask

	// Negedge at which the channel's end of cycle pulse is high
	task automatic waitCycleEnd(input int ch);
		int n;
		n = 0;
		@(negedge iCLK);
		while (!DUT.cycleCke[ch] && n < 2 * lpWindow + 8)
		begin
			@(negedge iCLK);
			n++;
		end
		if (!DUT.cycleCke[ch])
		begin
			errCount++;
			$display("Channel error in %s: channel %0d never finished a cycle", curTest, ch);
		end
	endtask

	task automatic countHigh(input int ch, input int clocks, output int highs);
		highs = 0;
		for (int i = 0; i < clocks; i++)
		begin
			@(negedge iCLK);
			if (oPwm[ch])
				highs++;
		end
	endtask

	// Duty window against (255 - ratio) * (div + 1)
	task automatic dutyCheck(input int ch, input logic [7:0] ratio, input int div);
		int highs;
		int expHigh;
		expHigh = (255 - int'(ratio)) * (div + 1);
		wbWrite(regAddr(ch, lpOffsDiv), 32'(div), 4'hF);
		wbWrite(regAddr(ch, lpOffsDuty), {24'h0, ratio}, 4'hF);
		wbWrite(regAddr(ch, lpOffsCtrl), 32'h1, 4'hF);
		waitCycleEnd(ch);
		countHigh(ch, 256 * (div + 1), highs);
		checkEq($sformatf("ch%0d ratio %0d div %0d high clocks", ch, ratio, div),
			32'(expHigh), 32'(highs));
		wbWrite(regAddr(ch, lpOffsCtrl), 32'h0, 4'hF);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	initial
	begin
		logic [31:0] val;
		int          highs;

		iWbCyc <= 1'b0;
		iWbStb <= 1'b0;
		iWbWe  <= 1'b0;
		iWbAdr <= '0;
		iWbDat <= '0;
		iWbSel <= '0;
		void'($urandom(44871));        // Single seed for the run

		wait (!iRST);
		@(negedge iCLK);

		// Reset values and readback
		startTest("resetReadback");
		checkEq("oPwm", 32'h0, 32'(oPwm));
		checkEq("oIrq", 32'h0, 32'(oIrq));
		for (int a = 0; a < 32; a++)
			readCheck($sformatf("reset adr %0d", a), 5'(a), 32'h0);
		for (int ch = 0; ch < lpChannels; ch++)
		begin
			val = $urandom;
			wbWrite(regAddr(ch, lpOffsCtrl), val, 4'hF);
			readCheck($sformatf("ctrl%0d", ch), regAddr(ch, lpOffsCtrl), {31'h0, val[0]});
			val = $urandom;
			wbWrite(regAddr(ch, lpOffsDuty), val, 4'hF);
			readCheck($sformatf("duty%0d", ch), regAddr(ch, lpOffsDuty), {24'h0, val[7:0]});
			val = $urandom;
			wbWrite(regAddr(ch, lpOffsDiv), val, 4'hF);
			readCheck($sformatf("div%0d", ch), regAddr(ch, lpOffsDiv), val);
		end
		val = $urandom;
		wbWrite(5'(lpAdrIrqEn), val, 4'hF);
		readCheck("irqEn", 5'(lpAdrIrqEn), {28'h0, val[3:0]});
		wbWrite(5'd3, 32'hFFFF_FFFF, 4'hF);       // Unmapped writes ignored
		readCheck("unmapped 3", 5'd3, 32'h0);
		readCheck("unmapped 20", 5'd20, 32'h0);
		readCheck("unmapped 31", 5'd31, 32'h0);
		// Back to idle so counters restart from zero
		for (int ch = 0; ch < lpChannels; ch++)
			wbWrite(regAddr(ch, lpOffsCtrl), 32'h0, 4'hF);
		wbWrite(5'(lpAdrIrqEn), 32'h0, 4'hF);
		wbWrite(5'(lpAdrIrqStat), 32'hF, 4'hF);
		endTest();

		// ----------------------------------------
		startTest("dutyRule");
		dutyCheck(0, 8'd0, int'($urandom_range(3, 0)));
		dutyCheck(1, 8'd255, int'($urandom_range(3, 0)));
		for (int i = 0; i < 4; i++)
			dutyCheck(i, 8'($urandom), int'($urandom_range(3, 0)));
		endTest();

		// ----------------------------------------
		startTest("cycleIrq");
		wbWrite(5'(lpAdrIrqStat), 32'hF, 4'hF);
		wbWrite(regAddr(0, lpOffsDiv), 32'h0, 4'hF);
		wbWrite(regAddr(0, lpOffsDuty), 32'(8'($urandom)), 4'hF);
		wbWrite(5'(lpAdrIrqEn), 32'h1, 4'hF);
		wbWrite(regAddr(0, lpOffsCtrl), 32'h1, 4'hF);
		waitCycleEnd(0);
		repeat (2) @(negedge iCLK);   // Status then oIrq
		checkEq("oIrq after cycle", 32'h1, 32'(oIrq));
		readCheck("status set", 5'(lpAdrIrqStat), 32'h1);
		wbWrite(5'(lpAdrIrqStat), 32'h1, 4'hF);
		repeat (2) @(negedge iCLK);
		checkEq("oIrq after clear", 32'h0, 32'(oIrq));
		readCheck("status cleared", 5'(lpAdrIrqStat), 32'h0);
		wbWrite(5'(lpAdrIrqEn), 32'h0, 4'hF);
		waitCycleEnd(0);
		repeat (2) @(negedge iCLK);
		checkEq("oIrq masked", 32'h0, 32'(oIrq));
		readCheck("status masked", 5'(lpAdrIrqStat), 32'h1);
		wbWrite(regAddr(0, lpOffsCtrl), 32'h0, 4'hF);
		wbWrite(5'(lpAdrIrqStat), 32'hF, 4'hF);
		endTest();

		// ----------------------------------------
		startTest("disable");
		for (int ch = 1; ch <= 2; ch++)
		begin
			wbWrite(regAddr(ch, lpOffsDiv), 32'h0, 4'hF);
			wbWrite(regAddr(ch, lpOffsDuty), 32'd100, 4'hF);
			wbWrite(regAddr(ch, lpOffsCtrl), 32'h1, 4'hF);
		end
		waitCycleEnd(1);
		wbWrite(regAddr(1, lpOffsCtrl), 32'h0, 4'hF);
		wbWrite(5'(lpAdrIrqStat), 32'hF, 4'hF);
		countHigh(1, 600, highs);                  // Two cycles of the other channel
		checkEq("ch1 high clocks off", 32'h0, 32'(highs));
		countHigh(2, 256, highs);
		checkEq("ch2 high clocks", 32'd155, 32'(highs));
		readCheck("status after disable", 5'(lpAdrIrqStat), 32'h4);
		wbWrite(regAddr(2, lpOffsCtrl), 32'h0, 4'hF);
		wbWrite(5'(lpAdrIrqStat), 32'hF, 4'hF);
		endTest();

		// ----------------------------------------
		startTest("byteSelect");
		wbWrite(regAddr(3, lpOffsDiv), 32'h1122_3344, 4'hF);
		wbWrite(regAddr(3, lpOffsDiv), 32'hAABB_CCDD, 4'b0101);
		readCheck("div sel 0101", regAddr(3, lpOffsDiv), 32'h11BB_33DD);   // Bytes 0 and 2 new
		wbWrite(regAddr(3, lpOffsDiv), 32'h5500_0000, 4'b1000);
		readCheck("div sel 1000", regAddr(3, lpOffsDiv), 32'h55BB_33DD);   // Top byte only
		endTest();

		repeat (4) @(posedge iCLK);
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`default_nettype none

// Clock with a period of 40 and a reset held for two cycles
module tbClock
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
	end

	always #20 clk = ~clk;

	initial
	begin
		repeat (2) @(posedge clk);
		rst <= 1'b0;              // Release on a rising edge
	end

endmodule

`default_nettype wire
